//--- design/dcache_defs.svh
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// Cache geometry with one 32-bit word per line
`define DC_INDEX_BITS 9
`define DC_TAG_BITS   3
`define DC_LINES      512

// Byte address split
`define DC_INDEX_RANGE 10:2
`define DC_TAG_RANGE   13:11

// Backing memory ignores address bits above 13
`define MEM_WORDS      4096
`define MEM_ADDR_BITS  12
`define MEM_WORD_RANGE 13:2

// Cycles from a memory request to its ready pulse
`define MEM_WAIT 3

`endif

//--- design/dcache_pkg.sv
`default_nettype none

`include "dcache_defs.svh"

package dcache_pkg;

  // CPU request held steady while stalled
  typedef struct packed {
    logic        sel;
    logic        we;
    logic [3:0]  mask;
    logic [31:0] addr;
    logic [31:0] wdata;
  } cpu_req_t;

  // Word-aligned main memory request
  typedef struct packed {
    logic        valid;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } mem_rsp_t;

  // SRAM write port
  typedef struct packed {
    logic                      cs;
    logic [3:0]                mask;
    logic [`DC_INDEX_BITS-1:0] index;
    logic [`DC_TAG_BITS-1:0]   tag;
    logic [31:0]               data;
  } sram_wr_t;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    WRITEBACK,
    REFILL,
    FILL_WRITE,
    CPU_WRITE,
    DONE
  } cache_state_e;

endpackage

`default_nettype wire

//--- design/dcache_sram.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defs.svh"

module dcache_sram (
  input  wire                          clk_i,
  input  wire dcache_pkg::sram_wr_t    wr_i,
  input  wire                          rd_en_i,
  input  wire [`DC_INDEX_BITS-1:0]     rd_index_i,
  output logic [`DC_TAG_BITS-1:0]      rd_tag_o,
  output logic [31:0]                  rd_data_o
);

  localparam int WIDTH = `DC_TAG_BITS + 32;

  // Tag in the upper bits and data word below
  logic [WIDTH-1:0] mem_q [`DC_LINES];

  // Write port with byte lanes gated by the mask
  always_ff @(posedge clk_i) begin
    if (wr_i.cs) begin
      mem_q[wr_i.index][32 +: `DC_TAG_BITS] <= wr_i.tag;
      for (int b = 0; b < 4; b++) begin
        if (wr_i.mask[b]) begin
          mem_q[wr_i.index][8*b +: 8] <= wr_i.data[8*b +: 8];
        end
      end
    end
  end

  // Read port output holds while not enabled
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_tag_o  <= mem_q[rd_index_i][32 +: `DC_TAG_BITS];
      rd_data_o <= mem_q[rd_index_i][31:0];
    end
  end

endmodule

`default_nettype wire

//--- design/dcache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defs.svh"

module dcache_ctrl (
  input  wire                          clk_i,
  input  wire                          rst_i,
  // CPU side
  input  wire dcache_pkg::cpu_req_t    cpu_req_i,
  output logic [31:0]                  rdata_o,
  output logic                         stall_o,
  // Main memory side
  output dcache_pkg::mem_req_t         mem_req_o,
  input  wire dcache_pkg::mem_rsp_t    mem_rsp_i,
  // SRAM side
  output dcache_pkg::sram_wr_t         sram_wr_o,
  output logic                         sram_rd_en_o,
  output logic [`DC_INDEX_BITS-1:0]    sram_rd_index_o,
  input  wire [`DC_TAG_BITS-1:0]       sram_rd_tag_i,
  input  wire [31:0]                   sram_rd_data_i
);

  import dcache_pkg::*;

  localparam int PAD_BITS = 30 - `DC_TAG_BITS - `DC_INDEX_BITS;

  cache_state_e state_q;
  cache_state_e state_d;

  // Per-line status bits
  logic [`DC_LINES-1:0] valid_q;
  logic [`DC_LINES-1:0] dirty_q;

  // Set for the cycle after a fill when the SRAM read is stale
  logic fwd_q;

  logic [31:0] fill_q;
  logic [31:0] rdata_q;

  logic [`DC_INDEX_BITS-1:0] index;
  logic [`DC_TAG_BITS-1:0]   tag;
  logic                      tag_hit;
  logic                      hit;
  logic [31:0]               lookup_word;
  logic [3:0]                wr_mask;
  logic [31:0]               victim_addr;

  assign index = cpu_req_i.addr[`DC_INDEX_RANGE];
  assign tag   = cpu_req_i.addr[`DC_TAG_RANGE];

  assign tag_hit     = valid_q[index] && (sram_rd_tag_i == tag);
  assign hit         = fwd_q || tag_hit;
  assign lookup_word = fwd_q ? fill_q : sram_rd_data_i;

  // Zero mask means full word
  assign wr_mask = (|cpu_req_i.mask) ? cpu_req_i.mask : 4'hF;

  // Victim address from stored tag and current index
  assign victim_addr = {{PAD_BITS{1'b0}}, sram_rd_tag_i, index, 2'b00};

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (cpu_req_i.sel) begin
          state_d = LOOKUP;
        end
      end
      LOOKUP: begin
        if (hit) begin
          state_d = cpu_req_i.we ? CPU_WRITE : DONE;
        end else if (dirty_q[index]) begin
          state_d = WRITEBACK;
        end else begin
          state_d = REFILL;
        end
      end
      WRITEBACK: begin
        if (mem_rsp_i.ready) begin
          state_d = REFILL;
        end
      end
      REFILL: begin
        if (mem_rsp_i.ready) begin
          state_d = FILL_WRITE;
        end
      end
      FILL_WRITE: begin
        // Reads go back through lookup
        state_d = cpu_req_i.we ? CPU_WRITE : LOOKUP;
      end
      CPU_WRITE: begin
        state_d = DONE;
      end
      DONE: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  assign stall_o = (state_d != IDLE);

  // Tag and data read for the lookup
  assign sram_rd_en_o    = (state_q == IDLE) && cpu_req_i.sel;
  assign sram_rd_index_o = index;

  // SRAM writes for the fill and the CPU store
  always_comb begin
    sram_wr_o       = '0;
    sram_wr_o.index = index;
    sram_wr_o.tag   = tag;
    case (state_q)
      FILL_WRITE: begin
        sram_wr_o.cs   = 1'b1;
        sram_wr_o.mask = 4'hF;
        sram_wr_o.data = fill_q;
      end
      CPU_WRITE: begin
        sram_wr_o.cs   = 1'b1;
        sram_wr_o.mask = wr_mask;
        sram_wr_o.data = cpu_req_i.wdata;
      end
      default: begin
        sram_wr_o.cs = 1'b0;
      end
    endcase
  end

  // Main memory requests held until ready
  always_comb begin
    mem_req_o = '0;
    case (state_q)
      WRITEBACK: begin
        // SRAM read output still holds the victim
        mem_req_o.valid = 1'b1;
        mem_req_o.we    = 1'b1;
        mem_req_o.addr  = victim_addr;
        mem_req_o.wdata = sram_rd_data_i;
      end
      REFILL: begin
        mem_req_o.valid = 1'b1;
        mem_req_o.addr  = {cpu_req_i.addr[31:2], 2'b00};
      end
      default: begin
        mem_req_o.valid = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      valid_q <= '0;
      dirty_q <= '0;
      fwd_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      fwd_q   <= (state_q == FILL_WRITE);
      if (state_q == FILL_WRITE) begin
        valid_q[index] <= 1'b1;
        dirty_q[index] <= 1'b0;
      end
      if (state_q == CPU_WRITE) begin
        dirty_q[index] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == REFILL) && mem_rsp_i.ready) begin
      fill_q <= mem_rsp_i.rdata;
    end
    if ((state_q == LOOKUP) && hit) begin
      rdata_q <= lookup_word;
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- design/main_mem.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defs.svh"

module main_mem (
  input  wire                          clk_i,
  input  wire                          rst_i,
  input  wire dcache_pkg::mem_req_t    req_i,
  output dcache_pkg::mem_rsp_t         rsp_o
);

  localparam int WAIT_BITS = $clog2(`MEM_WAIT + 1);

  logic [31:0]               mem_q [`MEM_WORDS];
  logic [WAIT_BITS-1:0]      wait_q;
  logic                      done;
  logic [`MEM_ADDR_BITS-1:0] word_addr;

  assign word_addr = req_i.addr[`MEM_WORD_RANGE];

  // Ready once the wait has elapsed
  assign done = req_i.valid && (wait_q == WAIT_BITS'(`MEM_WAIT));

  always_comb begin
    rsp_o.ready = done;
    rsp_o.rdata = mem_q[word_addr];
  end

  // Contents start at zero in simulation
  initial begin
    for (int i = 0; i < `MEM_WORDS; i++) begin
      mem_q[i] = '0;
    end
  end

  // Wait counter restarts after every ready pulse
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wait_q <= '0;
    end else if (done) begin
      wait_q <= '0;
    end else if (req_i.valid) begin
      wait_q <= wait_q + 1'b1;
    end
  end

  // Write takes effect in the ready cycle
  always @(posedge clk_i) begin
    if (done && req_i.we) begin
      mem_q[word_addr] <= req_i.wdata;
    end
  end

endmodule

`default_nettype wire

//--- design/dcache_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defs.svh"

module dcache_top (
  input  wire                          clk_i,
  input  wire                          rst_i,
  input  wire dcache_pkg::cpu_req_t    cpu_req_i,
  output logic [31:0]                  rdata_o,
  output logic                         stall_o
);

  import dcache_pkg::*;

  mem_req_t                  mem_req;
  mem_rsp_t                  mem_rsp;
  sram_wr_t                  sram_wr;
  logic                      sram_rd_en;
  logic [`DC_INDEX_BITS-1:0] sram_rd_index;
  logic [`DC_TAG_BITS-1:0]   sram_rd_tag;
  logic [31:0]               sram_rd_data;

  dcache_ctrl u_ctrl (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .cpu_req_i       (cpu_req_i),
    .rdata_o         (rdata_o),
    .stall_o         (stall_o),
    .mem_req_o       (mem_req),
    .mem_rsp_i       (mem_rsp),
    .sram_wr_o       (sram_wr),
    .sram_rd_en_o    (sram_rd_en),
    .sram_rd_index_o (sram_rd_index),
    .sram_rd_tag_i   (sram_rd_tag),
    .sram_rd_data_i  (sram_rd_data)
  );

  // Tag and data store
  dcache_sram u_sram (
    .clk_i      (clk_i),
    .wr_i       (sram_wr),
    .rd_en_i    (sram_rd_en),
    .rd_index_i (sram_rd_index),
    .rd_tag_o   (sram_rd_tag),
    .rd_data_o  (sram_rd_data)
  );

  main_mem u_mem (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .req_i (mem_req),
    .rsp_o (mem_rsp)
  );

endmodule

`default_nettype wire

//--- verification/dcache_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defs.svh"

module dcache_tb;

  import dcache_pkg::*;

  localparam int STALL_LIMIT = 40;
  localparam int COLD_N      = 16;
  localparam int WR_N        = 16;
  localparam int MASK_N      = 32;
  localparam int EVICT_N     = 8;
  localparam int EVICT_TAGS  = 4;
  localparam int MIX_N       = 400;
  localparam int TOTAL_REQ   = 2 * COLD_N + 4 * WR_N + 2 * MASK_N
                               + 2 * EVICT_N * EVICT_TAGS + MIX_N;
  localparam int CYCLE_LIMIT = TOTAL_REQ * STALL_LIMIT + 100;

  logic        clk;
  logic        rst;
  cpu_req_t    cpu_req;
  logic [31:0] rdata;
  logic        stall;

  // Flat reference memory
  logic [31:0] model_mem [`MEM_WORDS];

  logic [31:0] rng;
  int          error_count;
  int          req_count;
  int          cycle_count;

  dcache_top uut (
    .clk_i     (clk),
    .rst_i     (rst),
    .cpu_req_i (cpu_req),
    .rdata_o   (rdata),
    .stall_o   (stall)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Global limit on run length
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Run stopped after %0d cycles without finishing", CYCLE_LIMIT);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_random(output logic [31:0] r);
    rng = xorshift32(rng);
    r = rng;
  endtask

  function automatic logic [31:0] aligned_addr(input logic [31:0] r);
    return {18'd0, r[13:2], 2'b00};
  endfunction

  // One CPU request entered 1 ns after a rising edge
  task automatic cpu_access(input string name, input logic we, input logic [3:0] mask,
                            input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] got, output int cycles,
                            output logic ok);
    cpu_req.sel   = 1'b1;
    cpu_req.we    = we;
    cpu_req.mask  = mask;
    cpu_req.addr  = addr;
    cpu_req.wdata = wdata;
    req_count++;
    cycles = 0;
    // Sample stall late in each cycle
    #2;
    while (stall !== 1'b0 && cycles < STALL_LIMIT) begin
      cycles++;
      @(posedge clk);
      #3;
    end
    ok = (stall === 1'b0);
    if (!ok) begin
      $display("%s request to %h still stalled after %0d cycles", name, addr,
               STALL_LIMIT);
      error_count++;
    end
    got = rdata;
    @(posedge clk);
    #1;
    cpu_req.sel = 1'b0;
  endtask

  task automatic do_write(input string name, input logic [31:0] addr,
                          input logic [3:0] mask, input logic [31:0] wdata);
    logic [31:0] got;
    logic [3:0]  lanes;
    int          cycles;
    logic        ok;
    cpu_access(name, 1'b1, mask, addr, wdata, got, cycles, ok);
    lanes = (mask == 4'h0) ? 4'hF : mask;
    for (int b = 0; b < 4; b++) begin
      if (lanes[b]) begin
        model_mem[addr[`MEM_WORD_RANGE]][8*b +: 8] = wdata[8*b +: 8];
      end
    end
  endtask

  task automatic do_read(input string name, input logic [31:0] addr,
                         output int cycles);
    logic [31:0] got;
    logic [31:0] exp;
    logic        ok;
    exp = model_mem[addr[`MEM_WORD_RANGE]];
    cpu_access(name, 1'b0, 4'h0, addr, 32'h0, got, cycles, ok);
    if (ok && got !== exp) begin
      $display("FAILED %s addr %h: expected %h, actual %h", name, addr, exp, got);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input int start_errors,
                             input int start_reqs);
    $display("%s: %0d requests, %0d errors", name, req_count - start_reqs,
             error_count - start_errors);
  endtask

  initial begin
    logic [31:0]              r;
    logic [31:0]              d;
    logic [31:0]              addr;
    logic [3:0]               mask;
    logic [2:0]               base;
    logic [2:0]               tag3;
    logic [`DC_INDEX_BITS-1:0] idx;
    int                       c1;
    int                       c2;
    int                       e0;
    int                       q0;

    rst         = 1'b1;
    cpu_req     = '0;
    rng         = 32'h7ba2_5ed9;
    error_count = 0;
    req_count   = 0;
    cycle_count = 0;
    for (int i = 0; i < `MEM_WORDS; i++) begin
      model_mem[i] = '0;
    end

    // Stall must stay low with sel low during and after reset
    e0 = error_count;
    q0 = req_count;
    repeat (4) begin
      @(posedge clk);
      #1;
      if (stall !== 1'b0) begin
        $display("Stall output was high during reset");
        error_count++;
      end
    end
    rst = 1'b0;
    repeat (3) begin
      @(posedge clk);
      #1;
      if (stall !== 1'b0) begin
        $display("Stall output was high after reset with no request");
        error_count++;
      end
    end
    report_test("reset_state", e0, q0);

    // Untouched words read as zero and the second read hits
    e0 = error_count;
    q0 = req_count;
    for (int i = 0; i < COLD_N; i++) begin
      next_random(r);
      addr = aligned_addr(r);
      do_read("cold_read", addr, c1);
      do_read("cold_read", addr, c2);
      if (c2 != 2) begin
        $display("FAILED cold_read hit latency at %h: expected %0d, actual %0d",
                 addr, 2, c2);
        error_count++;
      end
    end
    report_test("cold_read", e0, q0);

    // Allocating write and readback, then a zero-mask hit write and readback
    e0 = error_count;
    q0 = req_count;
    for (int i = 0; i < WR_N; i++) begin
      next_random(r);
      addr = aligned_addr(r);
      next_random(d);
      do_write("write_read", addr, 4'hF, d);
      do_read("write_read", addr, c1);
      next_random(d);
      do_write("write_read", addr, 4'h0, d);
      do_read("write_read", addr, c1);
    end
    report_test("write_read", e0, q0);

    e0 = error_count;
    q0 = req_count;
    for (int i = 0; i < MASK_N; i++) begin
      next_random(r);
      // Small window so some writes hit
      addr = {22'd0, r[9:2], 2'b00};
      mask = r[23:20];
      if (mask == 4'h0 || mask == 4'hF) begin
        mask = 4'b0110;
      end
      next_random(d);
      do_write("byte_mask", addr, mask, d);
      do_read("byte_mask", addr, c1);
    end
    report_test("byte_mask", e0, q0);

    // Same index with different tags so later writes evict dirty lines
    e0 = error_count;
    q0 = req_count;
    for (int i = 0; i < EVICT_N; i++) begin
      next_random(r);
      base = r[13:11];
      idx  = r[10:2];
      for (int t = 0; t < EVICT_TAGS; t++) begin
        tag3 = base + 3'(t);
        next_random(d);
        do_write("conflict_evict", {18'd0, tag3, idx, 2'b00}, 4'hF, d);
      end
      for (int t = 0; t < EVICT_TAGS; t++) begin
        tag3 = base + 3'(t);
        do_read("conflict_evict", {18'd0, tag3, idx, 2'b00}, c1);
      end
    end
    report_test("conflict_evict", e0, q0);

    e0 = error_count;
    q0 = req_count;
    for (int i = 0; i < MIX_N; i++) begin
      next_random(r);
      addr = aligned_addr(r);
      if (r[31]) begin
        next_random(d);
        do_write("random_mix", addr, r[19:16], d);
      end else begin
        do_read("random_mix", addr, c1);
      end
    end
    report_test("random_mix", e0, q0);

    $display("Totals: %0d requests, %0d errors", req_count, error_count);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+design
design/dcache_pkg.sv
design/dcache_sram.sv
design/dcache_ctrl.sv
design/main_mem.sv
design/dcache_top.sv
verification/dcache_tb.sv
